/* sources.f */
+incdir+dv
hdl/top_system_pkg.sv
hdl/reset_pulse_gen.sv
hdl/wb_port_slave.sv
hdl/mem_arbiter.sv
hdl/mem_port.sv
hdl/top_system.sv
dv/tb_top_system.sv

/* Makefile */
# Verilator build and run of the top_system testbench

SIM := obj_dir/Vtb_top_system

.PHONY: all run clean

all: run

$(SIM): sources.f $(wildcard hdl/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)
	verilator --binary --timing --timescale 1ns/10ps --top-module tb_top_system -f sources.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "test failed" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "test passed" sim.log; then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* dv/tb_mem_model.svh */
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// Reference copy of the shared memory, updated in acknowledge order
data_t ref_mem [2**ADDR_W];

// Enabled bytes take the new data, the others keep the old word
function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                      input sel_t sel);
   data_t result;
   result = old_word;
   for (int b = 0; b < SEL_W; b++) begin
      if (sel[b]) begin
         result[b*8 +: 8] = new_word[b*8 +: 8];
      end
   end
   return result;
endfunction

// Word a read of this address must return
function automatic data_t expected_read(input addr_t adr);
   return ref_mem[adr];
endfunction

// Write as the memory applies it
task automatic apply_write(input addr_t adr, input data_t dat, input sel_t sel);
   ref_mem[adr] = merge_bytes(ref_mem[adr], dat, sel);
endtask

`endif

/* dv/tb_top_system.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_top_system
   import top_system_pkg::*;
();

   localparam int SEED       = 14;
   localparam int TIMEOUT    = 200;
   localparam int N_TRANS    = 200;
   // Random phase works inside these words only
   localparam int POOL_WORDS = 16;

   logic  clk;
   logic  reset;
   logic  m0_cyc;
   logic  m0_stb;
   logic  m0_we;
   addr_t m0_adr;
   data_t m0_dat_w;
   sel_t  m0_sel;
   data_t m0_dat_r;
   logic  m0_ack;
   logic  m1_cyc;
   logic  m1_stb;
   logic  m1_we;
   addr_t m1_adr;
   data_t m1_dat_w;
   sel_t  m1_sel;
   data_t m1_dat_r;
   logic  m1_ack;

   // Outstanding request per port, as the master issued it
   logic        pend   [N_PORTS];
   logic        p_we   [N_PORTS];
   addr_t       p_adr  [N_PORTS];
   data_t       p_dat  [N_PORTS];
   sel_t        p_sel  [N_PORTS];
   logic        prev_ack [N_PORTS];
   int          rel_cycles;

   `include "tb_mem_model.svh"

   top_system i_dut (
      .clk      (clk),
      .reset    (reset),
      .m0_cyc   (m0_cyc),
      .m0_stb   (m0_stb),
      .m0_we    (m0_we),
      .m0_adr   (m0_adr),
      .m0_dat_w (m0_dat_w),
      .m0_sel   (m0_sel),
      .m0_dat_r (m0_dat_r),
      .m0_ack   (m0_ack),
      .m1_cyc   (m1_cyc),
      .m1_stb   (m1_stb),
      .m1_we    (m1_we),
      .m1_adr   (m1_adr),
      .m1_dat_w (m1_dat_w),
      .m1_sel   (m1_sel),
      .m1_dat_r (m1_dat_r),
      .m1_ack   (m1_ack)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   // Cycles seen by the DUT with reset low
   always @(posedge clk) begin
      if (reset) begin
         rel_cycles <= 0;
      end else begin
         rel_cycles <= rel_cycles + 1;
      end
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic drive_request(input logic port, input logic we, input addr_t adr,
                                input data_t dat, input sel_t sel);
      if (port == 1'b0) begin
         m0_cyc   <= 1'b1;
         m0_stb   <= 1'b1;
         m0_we    <= we;
         m0_adr   <= adr;
         m0_dat_w <= dat;
         m0_sel   <= sel;
      end else begin
         m1_cyc   <= 1'b1;
         m1_stb   <= 1'b1;
         m1_we    <= we;
         m1_adr   <= adr;
         m1_dat_w <= dat;
         m1_sel   <= sel;
      end
   endtask

   task automatic release_request(input logic port);
      if (port == 1'b0) begin
         m0_cyc <= 1'b0;
         m0_stb <= 1'b0;
      end else begin
         m1_cyc <= 1'b0;
         m1_stb <= 1'b0;
      end
   endtask

   // One Wishbone classic cycle with the strobe held until ack
   task automatic wb_access(input logic port, input logic we, input addr_t adr,
                            input data_t dat, input sel_t sel);
      int   waited;
      logic got_ack;
      @(posedge clk);
      pend[port]   = 1'b1;
      p_we[port]   = we;
      p_adr[port]  = adr;
      p_dat[port]  = dat;
      p_sel[port]  = sel;
      drive_request(port, we, adr, dat, sel);
      waited  = 0;
      got_ack = 1'b0;
      while (!got_ack) begin
         @(negedge clk);
         got_ack = (port == 1'b0) ? m0_ack : m1_ack;
         waited++;
         if (!got_ack && waited > TIMEOUT) begin
            report_failure($sformatf("Timeout waiting for ack on port %0d", port));
         end
      end
      @(posedge clk);
      release_request(port);
   endtask

   task automatic check_port(input logic port, input logic ack, input data_t dat_r);
      data_t expected;
      if (ack === 1'b1) begin
         assert (rel_cycles > RST_START + RST_DURATION)
            else report_failure($sformatf("Port %0d acknowledged during internal reset", port));
         assert (prev_ack[port] !== 1'b1)
            else report_failure($sformatf("Ack on port %0d lasted more than one cycle", port));
         assert (pend[port] === 1'b1)
            else report_failure($sformatf("Ack on port %0d without a request", port));
         if (p_we[port]) begin
            apply_write(p_adr[port], p_dat[port], p_sel[port]);
         end else begin
            expected = expected_read(p_adr[port]);
            assert (dat_r === expected)
               else report_failure($sformatf(
                  "Mismatch at %0t: port %0d adr 0x%h read 0x%h expected 0x%h",
                  $time, port, p_adr[port], dat_r, expected));
         end
         pend[port] = 1'b0;
      end
   endtask

   // Outputs sampled mid-cycle away from the driving edge
   always @(negedge clk) begin
      check_port(1'b0, m0_ack, m0_dat_r);
      check_port(1'b1, m1_ack, m1_dat_r);
      prev_ack[0] = m0_ack;
      prev_ack[1] = m1_ack;
   end

   task automatic random_traffic(input logic port);
      logic  we;
      addr_t adr;
      data_t dat;
      sel_t  sel;
      for (int i = 0; i < N_TRANS; i++) begin
         we  = 1'($urandom_range(0, 1));
         adr = addr_t'($urandom_range(0, POOL_WORDS - 1));
         dat = $urandom;
         sel = sel_t'($urandom_range(1, 2**SEL_W - 1));
         wb_access(port, we, adr, dat, sel);
         repeat ($urandom_range(0, 3)) @(posedge clk);
      end
   endtask

   initial begin
      void'($urandom(SEED));
      reset    = 1'b1;
      m0_cyc   = 1'b0;
      m0_stb   = 1'b0;
      m0_we    = 1'b0;
      m0_adr   = '0;
      m0_dat_w = '0;
      m0_sel   = '0;
      m1_cyc   = 1'b0;
      m1_stb   = 1'b0;
      m1_we    = 1'b0;
      m1_adr   = '0;
      m1_dat_w = '0;
      m1_sel   = '0;
      for (int p = 0; p < N_PORTS; p++) begin
         pend[p]     = 1'b0;
         p_we[p]     = 1'b0;
         prev_ack[p] = 1'b0;
      end
      repeat (2) @(posedge clk);
      reset <= 1'b0;

      // Request issued while the internal reset pulse is still running
      wb_access(1'b0, 1'b1, 10'h3f0, 32'hcafe_0001, 4'hf);
      wb_access(1'b0, 1'b0, 10'h3f0, 32'h0, 4'hf);

      // Write then read back on one port
      wb_access(1'b1, 1'b1, 10'h064, 32'h1234_5678, 4'hf);
      wb_access(1'b1, 1'b0, 10'h064, 32'h0, 4'hf);

      // Partial byte enables
      wb_access(1'b0, 1'b1, 10'h0c8, 32'haabb_ccdd, 4'hf);
      wb_access(1'b0, 1'b1, 10'h0c8, 32'h1122_3344, 4'b0101);
      wb_access(1'b1, 1'b1, 10'h0c8, 32'h5566_7788, 4'b1000);
      wb_access(1'b0, 1'b0, 10'h0c8, 32'h0, 4'hf);

      // Fill the pool so every random read hits a written word
      for (int a = 0; a < POOL_WORDS; a++) begin
         wb_access(1'(a % 2), 1'b1, addr_t'(a), $urandom, 4'hf);
      end

      fork
         random_traffic(1'b0);
         random_traffic(1'b1);
      join

      // Idle cycles so a stray ack is still seen by the checker
      repeat (4) @(posedge clk);
      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

/* hdl/top_system.sv */
`timescale 1ns/10ps
`default_nettype none

module top_system
   import top_system_pkg::*;
(
   input  logic  clk,
   input  logic  reset,

   // Master 0 Wishbone port
   input  logic  m0_cyc,
   input  logic  m0_stb,
   input  logic  m0_we,
   input  addr_t m0_adr,
   input  data_t m0_dat_w,
   input  sel_t  m0_sel,
   output data_t m0_dat_r,
   output logic  m0_ack,

   // Master 1 Wishbone port
   input  logic  m1_cyc,
   input  logic  m1_stb,
   input  logic  m1_we,
   input  addr_t m1_adr,
   input  data_t m1_dat_w,
   input  sel_t  m1_sel,
   output data_t m1_dat_r,
   output logic  m1_ack
);

   logic       sys_rst;

   port_mask_t req;
   port_mask_t grant;
   port_mask_t rsp_hit;
   data_t      rsp_data;

   logic       req0_we;
   addr_t      req0_adr;
   data_t      req0_dat_w;
   sel_t       req0_sel;
   logic       req1_we;
   addr_t      req1_adr;
   data_t      req1_dat_w;
   sel_t       req1_sel;

   logic       mem_valid;
   logic       mem_port_id;
   logic       mem_we;
   addr_t      mem_adr;
   data_t      mem_dat_w;
   sel_t       mem_sel;

   // Internal reset, the pin alone is not reliable after power-up
   reset_pulse_gen reset_pulse (
      .clk     (clk),
      .reset   (reset),
      .sys_rst (sys_rst)
   );

   wb_port_slave port0 (
      .clk       (clk),
      .sys_rst   (sys_rst),
      .cyc       (m0_cyc),
      .stb       (m0_stb),
      .we        (m0_we),
      .adr       (m0_adr),
      .dat_w     (m0_dat_w),
      .sel       (m0_sel),
      .dat_r     (m0_dat_r),
      .ack       (m0_ack),
      .req       (req[0]),
      .req_we    (req0_we),
      .req_adr   (req0_adr),
      .req_dat_w (req0_dat_w),
      .req_sel   (req0_sel),
      .grant     (grant[0]),
      .rsp_hit   (rsp_hit[0]),
      .rsp_data  (rsp_data)
   );

   wb_port_slave port1 (
      .clk       (clk),
      .sys_rst   (sys_rst),
      .cyc       (m1_cyc),
      .stb       (m1_stb),
      .we        (m1_we),
      .adr       (m1_adr),
      .dat_w     (m1_dat_w),
      .sel       (m1_sel),
      .dat_r     (m1_dat_r),
      .ack       (m1_ack),
      .req       (req[1]),
      .req_we    (req1_we),
      .req_adr   (req1_adr),
      .req_dat_w (req1_dat_w),
      .req_sel   (req1_sel),
      .grant     (grant[1]),
      .rsp_hit   (rsp_hit[1]),
      .rsp_data  (rsp_data)
   );

   mem_arbiter arbiter (
      .clk         (clk),
      .sys_rst     (sys_rst),
      .req         (req),
      .req0_we     (req0_we),
      .req0_adr    (req0_adr),
      .req0_dat_w  (req0_dat_w),
      .req0_sel    (req0_sel),
      .req1_we     (req1_we),
      .req1_adr    (req1_adr),
      .req1_dat_w  (req1_dat_w),
      .req1_sel    (req1_sel),
      .grant       (grant),
      .mem_valid   (mem_valid),
      .mem_port_id (mem_port_id),
      .mem_we      (mem_we),
      .mem_adr     (mem_adr),
      .mem_dat_w   (mem_dat_w),
      .mem_sel     (mem_sel)
   );

   // Shared memory, responses carry the issuing port id back
   mem_port memory (
      .clk         (clk),
      .sys_rst     (sys_rst),
      .mem_valid   (mem_valid),
      .mem_port_id (mem_port_id),
      .mem_we      (mem_we),
      .mem_adr     (mem_adr),
      .mem_dat_w   (mem_dat_w),
      .mem_sel     (mem_sel),
      .rsp_hit     (rsp_hit),
      .rsp_data    (rsp_data)
   );

endmodule

`default_nettype wire

/* hdl/mem_port.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_port
   import top_system_pkg::*;
(
   input  logic       clk,
   input  logic       sys_rst,
   input  logic       mem_valid,
   input  logic       mem_port_id,
   input  logic       mem_we,
   input  addr_t      mem_adr,
   input  data_t      mem_dat_w,
   input  sel_t       mem_sel,
   output port_mask_t rsp_hit,
   output data_t      rsp_data
);

   // Stand-in for the external memory
   data_t mem [2**ADDR_W];

   // Response pipeline, stage 0 is loaded on the accept edge
   logic [MEM_LAT-1:0] valid_pipe;
   logic [MEM_LAT-1:0] tag_pipe;
   data_t              data_pipe [MEM_LAT];

   // Read returns the old word, also on a write
   always_ff @(posedge clk) begin
      if (mem_valid) begin
         data_pipe[0] <= mem[mem_adr];
         for (int b = 0; b < SEL_W; b++) begin
            if (mem_we && mem_sel[b]) begin
               mem[mem_adr][b*8 +: 8] <= mem_dat_w[b*8 +: 8];
            end
         end
      end
      tag_pipe[0] <= mem_port_id;
      for (int i = 1; i < MEM_LAT; i++) begin
         tag_pipe[i]  <= tag_pipe[i-1];
         data_pipe[i] <= data_pipe[i-1];
      end
   end

   always_ff @(posedge clk) begin
      if (sys_rst) begin
         valid_pipe <= '0;
      end else begin
         valid_pipe[0] <= mem_valid;
         for (int i = 1; i < MEM_LAT; i++) begin
            valid_pipe[i] <= valid_pipe[i-1];
         end
      end
   end

   // Tag selects which port sees the response
   always_comb begin
      rsp_hit = '0;
      if (valid_pipe[MEM_LAT-1]) rsp_hit[tag_pipe[MEM_LAT-1]] = 1'b1;
   end

   assign rsp_data = data_pipe[MEM_LAT-1];

endmodule

`default_nettype wire

/* hdl/mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter
   import top_system_pkg::*;
(
   input  logic       clk,
   input  logic       sys_rst,

   // Pending requests and their request words
   input  port_mask_t req,
   input  logic       req0_we,
   input  addr_t      req0_adr,
   input  data_t      req0_dat_w,
   input  sel_t       req0_sel,
   input  logic       req1_we,
   input  addr_t      req1_adr,
   input  data_t      req1_dat_w,
   input  sel_t       req1_sel,

   output port_mask_t grant,

   // Pipelined memory request
   output logic       mem_valid,
   output logic       mem_port_id,
   output logic       mem_we,
   output addr_t      mem_adr,
   output data_t      mem_dat_w,
   output sel_t       mem_sel
);

   logic last_port;
   logic pick;

   // Round robin: on a tie the port not served last wins
   always_comb begin
      pick = 1'b0;
      if (req[0] && req[1]) begin
         pick = ~last_port;
      end else if (req[1]) begin
         pick = 1'b1;
      end
      grant = '0;
      if (|req) grant[pick] = 1'b1;
   end

   always_ff @(posedge clk) begin
      if (sys_rst) begin
         mem_valid <= 1'b0;
         last_port <= 1'b1;
      end else begin
         mem_valid <= |req;
         if (|req) last_port <= pick;
      end
   end

   // Chosen request word, qualified by mem_valid downstream
   always_ff @(posedge clk) begin
      mem_port_id <= pick;
      mem_we      <= pick ? req1_we    : req0_we;
      mem_adr     <= pick ? req1_adr   : req0_adr;
      mem_dat_w   <= pick ? req1_dat_w : req0_dat_w;
      mem_sel     <= pick ? req1_sel   : req0_sel;
   end

endmodule

`default_nettype wire

/* hdl/wb_port_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_port_slave
   import top_system_pkg::*;
(
   input  logic  clk,
   input  logic  sys_rst,

   // Wishbone classic slave side
   input  logic  cyc,
   input  logic  stb,
   input  logic  we,
   input  addr_t adr,
   input  data_t dat_w,
   input  sel_t  sel,
   output data_t dat_r,
   output logic  ack,

   // Request toward the arbiter
   output logic  req,
   output logic  req_we,
   output addr_t req_adr,
   output data_t req_dat_w,
   output sel_t  req_sel,

   // Grant and response from the interconnect
   input  logic  grant,
   input  logic  rsp_hit,
   input  data_t rsp_data
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,
      ST_WAIT
   } state_t;

   state_t state;

   // A new cycle is only taken once the previous ack has gone by
   logic start;
   assign start = cyc && stb && (state == ST_IDLE) && !ack;

   assign req = (state == ST_REQ);

   always_ff @(posedge clk) begin
      if (sys_rst) begin
         state <= ST_IDLE;
         ack   <= 1'b0;
      end else begin
         ack <= 1'b0;
         case (state)
            ST_IDLE: if (start) state <= ST_REQ;
            ST_REQ:  if (grant) state <= ST_WAIT;
            ST_WAIT: begin
               if (rsp_hit) begin
                  state <= ST_IDLE;
                  ack   <= 1'b1;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Request word held stable until the memory has taken it
   always_ff @(posedge clk) begin
      if (start) begin
         req_we    <= we;
         req_adr   <= adr;
         req_dat_w <= dat_w;
         req_sel   <= sel;
      end
   end

   // Read data lines up with ack
   always_ff @(posedge clk) begin
      if ((state == ST_WAIT) && rsp_hit) begin
         dat_r <= rsp_data;
      end
   end

endmodule

`default_nettype wire

/* hdl/reset_pulse_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module reset_pulse_gen
   import top_system_pkg::*;
(
   input  logic clk,
   input  logic reset,
   output logic sys_rst
);

   // Counts cycles since reset release, saturates at the end of the pulse
   logic [$clog2(RST_START+RST_DURATION+1)-1:0] cnt;

   // The reset pin is not trusted after power-up, so the system stays in reset
   // through a start delay and then a fixed pulse of its own
   always_ff @(posedge clk) begin
      if (reset) begin
         cnt     <= '0;
         sys_rst <= 1'b1;
      end else begin
         if (cnt != (RST_START + RST_DURATION)) begin
            cnt <= cnt + 1'b1;
         end
         // Falls on edge number RST_START+RST_DURATION after release
         sys_rst <= (cnt < (RST_START + RST_DURATION - 1));
      end
   end

endmodule

`default_nettype wire

/* hdl/top_system_pkg.sv */
`default_nettype none

package top_system_pkg;

   // Memory geometry
   localparam int ADDR_W = 10;
   localparam int DATA_W = 32;
   localparam int SEL_W  = DATA_W / 8;

   // System-side masters sharing the memory
   localparam int N_PORTS = 2;

   // Cycles from memory accept to response
   localparam int MEM_LAT = 2;

   // Internal reset pulse timing, in clk cycles
   localparam int RST_START    = 5;
   localparam int RST_DURATION = 10;

   // Word address, data word and byte enables
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [SEL_W-1:0]  sel_t;

   // One bit per port for requests, grant and response hits
   typedef logic [N_PORTS-1:0] port_mask_t;

endpackage

`default_nettype wire
